/* design/dirty_block.sv */
// Deduplicating dirty-line buffer over the slot array and two slot finders
`timescale 1ns/1ps
`default_nettype none

module dirty_block (
	input  logic                  CLK,
	input  logic                  reset_i,
	input  logic                  push_i,        // Store seen this cycle
	input  logic                  pop_i,         // Drain the head slot
	input  dirty_pkg::line_addr_t addr_i,
	output dirty_pkg::line_addr_t addr_o,        // Head line address
	output logic                  empty_o,
	output logic                  full_o         // Full and no matching entry
);

	import dirty_pkg::*;

	slot_mask_t              valid;
	line_addr_t [SLOT_N-1:0] slots;
	slot_mask_t              hit;            // Per-slot address match
	slot_idx_t               head_pos;
	slot_idx_t               free_pos;
	slot_idx_t               idx;
	logic                    head_none;
	logic                    free_none;
	logic                    push_new;       // Push that is not a duplicate
	logic                    wr;
	logic                    clr;
	logic                    slots_empty;
	logic                    slots_full;

	// Compare against every valid slot, the one being popped included
	always_comb begin
		for (int i = 0; i < SLOT_N; i++) begin
			hit[i] = valid[i] & (slots[i] == addr_i);
		end
	end

	assign push_new = push_i & ~|hit;

	assign clr = pop_i & ~head_none;         // Never clear an empty buffer
	assign wr  = push_new & ~free_none;      // Full buffer takes no store, pop or not

	// Popped slot is reused by a same-cycle store
	assign idx = clr ? head_pos : free_pos;

	dirty_slots u_slots (
		.CLK     (CLK),
		.reset_i (reset_i),
		.wr_i    (wr),
		.clr_i   (clr),
		.idx_i   (idx),
		.addr_i  (addr_i),
		.valid_o (valid),
		.slots_o (slots),
		.empty_o (slots_empty),
		.full_o  (slots_full)
	);

	// Head is the lowest valid slot
	slot_finder u_head_find (
		.mask_i (valid),
		.pos_o  (head_pos),
		.none_o (head_none)
	);

	// First free slot is the lowest invalid one
	slot_finder u_free_find (
		.mask_i (~valid),
		.pos_o  (free_pos),
		.none_o (free_none)
	);

	assign addr_o  = slots[head_pos];
	assign empty_o = slots_empty;
	assign full_o  = slots_full & ~|hit;     // Repeat store never stalls

endmodule

`default_nettype wire

/* design/dirty_pkg.sv */
// Tracker widths, slot depth, store report and write-back command structs
`default_nettype none

package dirty_pkg;

	// 32-bit byte address, 64-byte lines
	localparam int LINE_ADDR_W = 26;
	localparam int SLOT_N      = 16;         // Tracker depth
	localparam int SLOT_IDX_W  = 4;          // log2 of SLOT_N

	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [SLOT_IDX_W-1:0]  slot_idx_t;
	typedef logic [SLOT_N-1:0]      slot_mask_t; // One bit per slot

	// Store report from the cache, one beat per cycle
	typedef struct packed {
		logic       valid;                   // Store strobe
		line_addr_t addr;                    // Line that became dirty
	} store_req_t;

	// One write-back command toward memory
	typedef struct packed {
		logic       valid;
		logic       last;                    // Final line of this flush
		line_addr_t addr;                    // Line to write back
	} wb_cmd_t;

endpackage

`default_nettype wire

/* design/dirty_slots.sv */
// Slot array of line addresses with valid bits, indexed write and clear
`timescale 1ns/1ps
`default_nettype none

module dirty_slots (
	input  logic                                      CLK,
	input  logic                                      reset_i,
	input  logic                                      wr_i,    // Fill slot idx_i
	input  logic                                      clr_i,   // Free slot idx_i
	input  dirty_pkg::slot_idx_t                      idx_i,
	input  dirty_pkg::line_addr_t                     addr_i,
	output dirty_pkg::slot_mask_t                     valid_o,
	output dirty_pkg::line_addr_t [dirty_pkg::SLOT_N-1:0] slots_o,
	output logic                                      empty_o,
	output logic                                      full_o
);

	import dirty_pkg::*;

	slot_mask_t                 valid_q;
	line_addr_t [SLOT_N-1:0]    slots_q;

	// Valid bits
	// A write on a slot being cleared keeps it valid, so the slot is reused
	always_ff @(posedge CLK) begin
		if (reset_i) begin
			valid_q <= '0;
		end else if (wr_i) begin
			valid_q[idx_i] <= 1'b1;
		end else if (clr_i) begin
			valid_q[idx_i] <= 1'b0;
		end
	end

	// Address storage, only touched on a write
	always_ff @(posedge CLK) begin
		if (wr_i) begin
			slots_q[idx_i] <= addr_i;
		end
	end

	assign valid_o = valid_q;
	assign slots_o = slots_q;

	assign empty_o = ~|valid_q;              // Nothing recorded
	assign full_o  = &valid_q;               // Every slot taken

endmodule

`default_nettype wire

/* design/dirty_tracker_top.sv */
// Top level joining the write-back controller and the dirty-line buffer
`timescale 1ns/1ps
`default_nettype none

module dirty_tracker_top (
	input  logic                  CLK,
	input  logic                  reset_i,
	input  dirty_pkg::store_req_t store_i,       // Store report from the cache
	input  logic                  flush_i,       // Start a flush
	input  logic                  mem_busy_i,    // Memory takes nothing now
	output logic                  store_stall_o, // Cache must retry the store
	output dirty_pkg::wb_cmd_t    wb_o,
	output logic                  flush_done_o
);

	import dirty_pkg::*;

	logic       push;
	logic       pop;
	logic       empty;
	logic       full;
	line_addr_t head_addr;               // Lowest valid slot

	writeback_ctrl u_ctrl (
		.CLK           (CLK),
		.reset_i       (reset_i),
		.store_i       (store_i),
		.flush_i       (flush_i),
		.mem_busy_i    (mem_busy_i),
		.head_addr_i   (head_addr),
		.empty_i       (empty),
		.full_i        (full),
		.push_o        (push),
		.pop_o         (pop),
		.store_stall_o (store_stall_o),
		.wb_o          (wb_o),
		.flush_done_o  (flush_done_o)
	);

	// Store address bypasses the controller
	dirty_block u_dirty (
		.CLK     (CLK),
		.reset_i (reset_i),
		.push_i  (push),
		.pop_i   (pop),
		.addr_i  (store_i.addr),
		.addr_o  (head_addr),
		.empty_o (empty),
		.full_o  (full)
	);

endmodule

`default_nettype wire

/* design/slot_finder.sv */
// Priority encoder for the lowest set bit of a slot mask, with all-zero flag
`timescale 1ns/1ps
`default_nettype none

module slot_finder (
	input  dirty_pkg::slot_mask_t mask_i,
	output dirty_pkg::slot_idx_t  pos_o,
	output logic                  none_o
);

	import dirty_pkg::*;

	// Walk down from the top so the lowest set bit lands last
	always_comb begin
		pos_o = '0;                          // Don't care when mask is zero
		for (int i = SLOT_N - 1; i >= 0; i--) begin
			if (mask_i[i]) begin
				pos_o = slot_idx_t'(i);
			end
		end
	end

	assign none_o = ~|mask_i;                // No bit set anywhere

endmodule

`default_nettype wire

/* design/writeback_ctrl.sv */
// Flush FSM issuing paced pops and write-back commands, store stall, done pulse
`timescale 1ns/1ps
`default_nettype none

module writeback_ctrl (
	input  logic                  CLK,
	input  logic                  reset_i,
	input  dirty_pkg::store_req_t store_i,
	input  logic                  flush_i,
	input  logic                  mem_busy_i,
	input  dirty_pkg::line_addr_t head_addr_i,
	input  logic                  empty_i,
	input  logic                  full_i,
	output logic                  push_o,
	output logic                  pop_o,
	output logic                  store_stall_o,
	output dirty_pkg::wb_cmd_t    wb_o,
	output logic                  flush_done_o
);

	import dirty_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		DRAIN,
		DONE
	} state_t;

	state_t     state_q;
	state_t     state_d;
	logic       wb_vld_q;                    // Command issued last cycle
	line_addr_t wb_addr_q;
	wb_cmd_t    wb_cmd;

	// Every store strobe goes to the buffer, which drops duplicates itself
	assign push_o        = store_i.valid;
	assign store_stall_o = store_i.valid & full_i;

	// One pop per free memory cycle while lines remain
	assign pop_o = (state_q == DRAIN) & ~mem_busy_i & ~empty_i;

	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (flush_i) begin
					state_d = DRAIN;
				end
			end
			// Empty here means the last command is out or there was none
			DRAIN: begin
				if (empty_i) begin
					state_d = DONE;
				end
			end
			DONE:    state_d = IDLE;         // Single done cycle
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset_i) begin
			state_q  <= IDLE;
			wb_vld_q <= 1'b0;
		end else begin
			state_q  <= state_d;
			wb_vld_q <= pop_o;
		end
	end

	// Command address follows the popped head
	always_ff @(posedge CLK) begin
		if (pop_o) begin
			wb_addr_q <= head_addr_i;
		end
	end

	// Buffer still empty after the pop edge marks the final line
	always_comb begin
		wb_cmd.valid = wb_vld_q;
		wb_cmd.last  = wb_vld_q & empty_i;
		wb_cmd.addr  = wb_addr_q;
	end

	assign wb_o         = wb_cmd;
	assign flush_done_o = (state_q == DONE);

endmodule

`default_nettype wire

/* filelist.f */
design/dirty_pkg.sv
design/slot_finder.sv
design/dirty_slots.sv
design/dirty_block.sv
design/writeback_ctrl.sv
design/dirty_tracker_top.sv
testbench/tb_dirty_tracker.sv

/* run.sh */
#!/bin/sh
# Compile the dirty tracker testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_dirty_tracker -f filelist.f -Mdir obj_dir &&
./obj_dir/Vtb_dirty_tracker ||
{ echo "simulation did not pass"; exit 1; }

/* testbench/tb_dirty_tracker.sv */
// Dirty tracker testbench with clock, reset, stimulus table, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_dirty_tracker;

	import dirty_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 2;

	// One cycle of stimulus plus the outputs expected in that cycle
	typedef struct packed {
		store_req_t store;
		logic       flush;
		logic       busy;
		logic       stall;                   // Expected store_stall_o
		wb_cmd_t    wb;                      // Expected wb_o
		logic       done;                    // Expected flush_done_o
	} row_t;

	logic       clk;
	logic       reset_i;
	store_req_t store;
	logic       flush;
	logic       mem_busy;
	logic       store_stall;
	wb_cmd_t    wb;
	logic       flush_done;
	row_t       rows[$];
	logic       table_ready;                 // Table built, watchdog may start

	dirty_tracker_top DUT (
		.CLK           (clk),
		.reset_i       (reset_i),
		.store_i       (store),
		.flush_i       (flush),
		.mem_busy_i    (mem_busy),
		.store_stall_o (store_stall),
		.wb_o          (wb),
		.flush_done_o  (flush_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic store_req_t store_beat(input line_addr_t addr);
		return '{valid: 1'b1, addr: addr};
	endfunction

	function automatic store_req_t no_store();
		return '{valid: 1'b0, addr: '0};
	endfunction

	function automatic wb_cmd_t wb_cmd(input line_addr_t addr, input logic last);
		return '{valid: 1'b1, last: last, addr: addr};
	endfunction

	function automatic wb_cmd_t no_cmd();
		return '{valid: 1'b0, last: 1'b0, addr: '0};
	endfunction

	// Distinct line per fill index, used to fill all 16 slots
	function automatic line_addr_t fill_line(input int i);
		return line_addr_t'(32'h0200_0000 + i * 32'h41);
	endfunction

	// Command seen one cycle after popping fill index idx, none if no pop
	function automatic wb_cmd_t drained_cmd(input int idx);
		return (idx < 0) ? no_cmd() : wb_cmd(fill_line(idx), 1'b0);
	endfunction

	task automatic add_row(input store_req_t st, input logic fl, input logic busy,
			input logic stall, input wb_cmd_t exp_wb, input logic done);
		rows.push_back('{store: st, flush: fl, busy: busy, stall: stall, wb: exp_wb,
			done: done});
	endtask

	// No stimulus, only the write-back side is expected to move
	task automatic add_quiet(input wb_cmd_t exp_wb, input logic done);
		add_row(no_store(), 1'b0, 1'b0, 1'b0, exp_wb, done);
	endtask

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_wb(input wb_cmd_t got, input wb_cmd_t exp, input int row);
		// Address only matters on a valid command
		if (got.valid !== exp.valid || got.last !== exp.last ||
				(exp.valid && got.addr !== exp.addr)) begin
			fail_run($sformatf("ERR %0t: row %0d wb_o v=%b l=%b a=%h, expected v=%b l=%b a=%h",
				$time, row, got.valid, got.last, got.addr, exp.valid, exp.last, exp.addr));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name,
			input int row);
		if (got !== exp) begin
			fail_run($sformatf("ERR %0t: row %0d %s is %b, expected %b",
				$time, row, name, got, exp));
		end
	endtask

	task automatic build_table();
		int prev;
		add_quiet(no_cmd(), 1'b0);                          // Outputs low out of reset
		// Three distinct lines, drained in slot order
		add_row(store_beat(26'h0000040), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_row(store_beat(26'h1234567), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_row(store_beat(26'h3fffffc), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_row(no_store(), 1'b1, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_quiet(no_cmd(), 1'b0);                          // Pop slot 0
		add_row(no_store(), 1'b1, 1'b0, 1'b0, wb_cmd(26'h0000040, 1'b0), 1'b0); // Flush in DRAIN
		add_quiet(wb_cmd(26'h1234567, 1'b0), 1'b0);
		add_quiet(wb_cmd(26'h3fffffc, 1'b1), 1'b0);
		add_quiet(no_cmd(), 1'b1);
		add_quiet(no_cmd(), 1'b0);                          // Single pulse
		// Same line three times, one entry
		repeat (3) add_row(store_beat(26'h0abc000), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_row(no_store(), 1'b1, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_quiet(no_cmd(), 1'b0);
		add_quiet(wb_cmd(26'h0abc000, 1'b1), 1'b0);
		add_quiet(no_cmd(), 1'b1);
		// Fill all slots
		for (int i = 0; i < SLOT_N; i++) begin
			add_row(store_beat(fill_line(i)), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0);
		end
		add_row(store_beat(26'h3000000), 1'b0, 1'b0, 1'b1, no_cmd(), 1'b0); // New line stalls
		add_row(store_beat(fill_line(5)), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0); // Known line
		add_row(no_store(), 1'b1, 1'b0, 1'b0, no_cmd(), 1'b0);
		// Drain with two busy stretches
		prev = -1;
		for (int i = 0; i < SLOT_N; i++) begin
			if (i == 4 || i == 9) begin
				repeat (3) begin
					add_row(no_store(), 1'b0, 1'b1, 1'b0, drained_cmd(prev), 1'b0);
					prev = -1;
				end
			end
			add_quiet(drained_cmd(prev), 1'b0);
			prev = i;
		end
		add_quiet(wb_cmd(fill_line(SLOT_N - 1), 1'b1), 1'b0);
		add_quiet(no_cmd(), 1'b1);
		// Store during drain, popped line repeated then new line into freed slot
		add_row(store_beat(26'h0000001), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_row(store_beat(26'h0000002), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_row(no_store(), 1'b1, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_row(store_beat(26'h0000001), 1'b0, 1'b0, 1'b0, no_cmd(), 1'b0); // Dup of popped
		add_row(store_beat(26'h1fff000), 1'b0, 1'b0, 1'b0, wb_cmd(26'h0000001, 1'b0), 1'b0);
		add_quiet(wb_cmd(26'h0000002, 1'b0), 1'b0);
		add_quiet(wb_cmd(26'h1fff000, 1'b1), 1'b0);
		add_quiet(no_cmd(), 1'b1);
		// Flush of an empty buffer
		add_row(no_store(), 1'b1, 1'b0, 1'b0, no_cmd(), 1'b0);
		add_quiet(no_cmd(), 1'b0);
		add_quiet(no_cmd(), 1'b1);
		add_quiet(no_cmd(), 1'b0);
	endtask

	// Watchdog, scaled to the table length
	initial begin
		wait (table_ready === 1'b1);
		#((rows.size() + RESET_CYCLES + 20) * CLK_PERIOD);
		fail_run("watchdog expired: table did not finish");
	end

	initial begin
		table_ready = 1'b0;
		reset_i     = 1'b1;
		store       = no_store();
		flush       = 1'b0;
		mem_busy    = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_i = 1'b0;
		for (int r = 0; r < rows.size(); r++) begin
			@(posedge clk);
			#1;                                  // Drive just after the edge
			store    = rows[r].store;
			flush    = rows[r].flush;
			mem_busy = rows[r].busy;
			#2;                                  // Sample before the next edge
			check_flag(store_stall, rows[r].stall, "store_stall_o", r);
			check_wb(wb, rows[r].wb, r);
			check_flag(flush_done, rows[r].done, "flush_done_o", r);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
